//--- hyper_pkg.sv
/*
 * Shared widths, sequencer states and the command-address word.
 * The bus is modelled as one 16-bit word per clk0 cycle.
 * The bus word width is WORD_W; DATA_W is the write-data state.
 */
package hyper_pkg;

    localparam int NUM_CS  = 2;   // one-hot chip selects
    localparam int BURST_W = 12;
    localparam int ADDR_W  = 32;  // byte address
    localparam int WORD_W  = 16;  // bus word
    localparam int STRB_W  = 2;
    localparam int CFG_W   = 4;   // latency and recovery fields

    typedef enum logic [3:0] {
        IDLE,
        CA,       // three command-address words
        LAT2,     // first latency block, RWDS checked here
        LAT,      // second block, only when latency is doubled
        DATA_W,
        DATA_R,
        HOLD_R,   // read buffer full, clock held
        LAST_R,   // last read word requested, wait for its take
        RECOVER
    } hyper_state_e;

    // 48-bit command-address, filled as fields and sent as words
    typedef union packed {
        struct packed {
            logic        read;      // 1 = read
            logic        space;     // 1 = register space
            logic        linear;    // 1 = linear burst
            logic [28:0] addr_hi;   // byte address 31..3
            logic [12:0] rsvd;
            logic [2:0]  addr_lo;   // byte address 2..0
        } f;
        logic [2:0][WORD_W-1:0] w;  // w[2] goes out first
    } hyper_ca_u;

endpackage

//--- hyper_ca_decode.sv
/*
 * Local copy of the transaction and the command-address build.
 * The copy follows the inputs while load_i is high (sequencer idle),
 * so the inputs must hold while trans_valid_i is high.
 * trans_burst_type_i high selects a linear burst.
 */
`timescale 1ns/100ps

module hyper_ca_decode import hyper_pkg::*; (
    input  logic               clk0,
    input  logic               rst_ni,
    input  logic               load_i,
    input  logic [ADDR_W-1:0]  trans_address_i,
    input  logic [NUM_CS-1:0]  trans_cs_i,
    input  logic               trans_write_i,
    input  logic [BURST_W-1:0] trans_burst_i,
    input  logic               trans_burst_type_i,
    input  logic               trans_address_space_i,
    output logic [NUM_CS-1:0]  cs_o,
    output logic               write_o,
    output logic [BURST_W-1:0] burst_o,
    output hyper_ca_u          ca_o
);

    logic [ADDR_W-1:0] addr_q;
    logic              burst_type_q;
    logic              space_q;

    always_ff @(posedge clk0 or negedge rst_ni) begin
        if (!rst_ni) begin
            cs_o    <= '0;
            write_o <= 1'b0;
        end else if (load_i) begin
            cs_o    <= trans_cs_i;
            write_o <= trans_write_i;
        end
    end

    always_ff @(posedge clk0) begin
        if (load_i) begin
            addr_q       <= trans_address_i;
            burst_o      <= trans_burst_i;
            burst_type_q <= trans_burst_type_i;
            space_q      <= trans_address_space_i;
        end
    end

    always_comb begin
        ca_o           = '0;
        ca_o.f.read    = ~write_o;
        ca_o.f.space   = space_q;
        ca_o.f.linear  = burst_type_q;
        ca_o.f.addr_hi = addr_q[ADDR_W-1:3];
        ca_o.f.addr_lo = addr_q[2:0];
    end

    // an accepted transaction selects exactly one chip
    assert property (@(posedge clk0) disable iff (!rst_ni) $fell(load_i) |-> $onehot(cs_o));

endmodule

//--- hyper_seq.sv
/*
 * Transaction sequencer: command, latency, data and recovery phases.
 * cfg_latency_i and the burst length must be at least 1; a recovery of 0 acts as 1.
 * RWDS is checked in the first latency cycle, which the bus shows as the third CA word.
 * Reads keep one word in flight: the memory answers in its enabled cycle,
 * and the word is captured one cycle after the enable leaves the sequencer.
 */
`timescale 1ns/100ps

module hyper_seq import hyper_pkg::*; (
    input  logic               clk0,
    input  logic               rst_ni,
    input  logic               trans_valid_i,
    input  logic [CFG_W-1:0]   cfg_latency_i,
    input  logic               cfg_add_latency_i,
    input  logic [CFG_W-1:0]   cfg_recovery_i,
    input  logic               write_i,
    input  logic [BURST_W-1:0] burst_i,
    input  logic               tx_valid_i,
    input  logic               rx_full_i,
    input  logic               rx_take_i,
    input  logic               rwds_i,
    output logic               load_o,
    output logic               trans_ready_o,
    output logic               tx_ready_o,
    output logic               b_valid_o,
    output hyper_state_e       state_o,
    output logic [1:0]         ca_sel_o,
    output logic               ck_en_o,
    output logic               cs_en_o,
    output logic               rx_last_o,
    output logic               capture_o
);

    hyper_state_e       state_q;
    hyper_state_e       data_state;
    logic [CFG_W-1:0]   wait_cnt;
    logic [BURST_W-1:0] burst_cnt;
    logic [1:0]         ca_sel_q;
    logic               rwds_chk;   // first latency cycle
    logic               rwds_q;
    logic               lat_double;
    logic               burst_last;
    logic               rd_issue;
    logic               cap_q;
    logic               last_q;
    logic               b_q;

    assign data_state = write_i ? DATA_W : DATA_R;
    assign lat_double = cfg_add_latency_i || (rwds_chk ? rwds_i : rwds_q);
    assign burst_last = burst_cnt == BURST_W'(1);
    // request a read word only when nothing is pending and the buffer frees up
    assign rd_issue   = (state_q == DATA_R) && !cap_q && (!rx_full_i || rx_take_i);

    always_ff @(posedge clk0 or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q   <= IDLE;
            wait_cnt  <= '0;
            burst_cnt <= '0;
            ca_sel_q  <= 2'd0;
            rwds_chk  <= 1'b0;
            rwds_q    <= 1'b0;
            cap_q     <= 1'b0;
            last_q    <= 1'b0;
            b_q       <= 1'b0;
        end else begin
            rwds_chk <= (state_q == CA) && (ca_sel_q == 2'd2);
            if (rwds_chk) rwds_q <= rwds_i;
            cap_q  <= rd_issue;
            last_q <= rd_issue && burst_last;
            b_q    <= (state_q == DATA_W) && tx_valid_i && burst_last;

            case (state_q)
                IDLE: begin
                    ca_sel_q <= 2'd0;
                    if (trans_valid_i) state_q <= CA;
                end
                CA: begin
                    if (ca_sel_q == 2'd2) begin
                        state_q  <= LAT2;
                        wait_cnt <= cfg_latency_i - 1'b1;
                    end else begin
                        ca_sel_q <= ca_sel_q + 2'd1;
                    end
                end
                LAT2: begin
                    if (wait_cnt != '0) begin
                        wait_cnt <= wait_cnt - 1'b1;
                    end else if (lat_double) begin
                        state_q  <= LAT;
                        wait_cnt <= cfg_latency_i - 1'b1;
                    end else begin
                        state_q   <= data_state;
                        burst_cnt <= burst_i;
                    end
                end
                LAT: begin
                    if (wait_cnt != '0) begin
                        wait_cnt <= wait_cnt - 1'b1;
                    end else begin
                        state_q   <= data_state;
                        burst_cnt <= burst_i;
                    end
                end
                DATA_W: begin
                    if (tx_valid_i) begin   // stall otherwise, clock stays off
                        burst_cnt <= burst_cnt - 1'b1;
                        if (burst_last) begin
                            state_q  <= RECOVER;
                            wait_cnt <= cfg_recovery_i;
                        end
                    end
                end
                DATA_R: begin
                    if (rd_issue) begin
                        burst_cnt <= burst_cnt - 1'b1;
                        if (burst_last) state_q <= LAST_R;
                    end else if (!cap_q) begin
                        state_q <= HOLD_R;  // full and not taken
                    end
                end
                HOLD_R: if (rx_take_i) state_q <= DATA_R;
                LAST_R: begin
                    if (rx_take_i && !cap_q) begin
                        state_q  <= RECOVER;
                        wait_cnt <= cfg_recovery_i;
                    end
                end
                RECOVER: begin
                    if (wait_cnt <= CFG_W'(1)) state_q <= IDLE;
                    else wait_cnt <= wait_cnt - 1'b1;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_comb begin
        case (state_q)
            CA, LAT2, LAT: ck_en_o = 1'b1;
            DATA_W:        ck_en_o = tx_valid_i;
            DATA_R:        ck_en_o = rd_issue;
            default:       ck_en_o = 1'b0;
        endcase
    end

    assign cs_en_o       = (state_q != IDLE) && (state_q != RECOVER);
    assign load_o        = state_q == IDLE;
    assign trans_ready_o = (state_q == CA) && (ca_sel_q == 2'd0);
    assign tx_ready_o    = state_q == DATA_W;
    assign b_valid_o     = b_q;
    assign state_o       = state_q;
    assign ca_sel_o      = ca_sel_q;
    assign capture_o     = cap_q;
    assign rx_last_o     = last_q;

    assert property (@(posedge clk0) disable iff (!rst_ni)
        tx_ready_o |-> burst_cnt != '0);

    // a zero burst or an extra word would wrap the counter
    assert property (@(posedge clk0) disable iff (!rst_ni)
        (burst_cnt == '0) |-> !(rd_issue || (tx_ready_o && tx_valid_i)));

endmodule

//--- hyper_bus_drive.sv
/*
 * Drives the memory bus through one register stage.
 * Word, strobe, enables and chip select reach the bus one cycle after selection.
 * hyper_rwds_o carries the byte strobe as is, high = byte written.
 */
`timescale 1ns/100ps

module hyper_bus_drive import hyper_pkg::*; (
    input  logic              clk0,
    input  logic              rst_ni,
    input  hyper_state_e      state_i,
    input  hyper_ca_u         ca_i,
    input  logic [1:0]        ca_sel_i,
    input  logic              ck_en_i,
    input  logic              cs_en_i,
    input  logic [NUM_CS-1:0] cs_i,
    input  logic [WORD_W-1:0] tx_data_i,
    input  logic [STRB_W-1:0] tx_strb_i,
    output logic [WORD_W-1:0] hyper_dq_o,
    output logic [STRB_W-1:0] hyper_rwds_o,
    output logic              hyper_dq_oe_o,
    output logic              hyper_rwds_oe_o,
    output logic              hyper_ck_en_o,
    output logic [NUM_CS-1:0] hyper_cs_no
);

    logic [WORD_W-1:0] word_d;
    logic              wr_data;

    assign wr_data = state_i == DATA_W;

    always_comb begin
        case (ca_sel_i)
            2'd0:    word_d = ca_i.w[2];
            2'd1:    word_d = ca_i.w[1];
            2'd2:    word_d = ca_i.w[0];
            default: word_d = '0;
        endcase
        if (wr_data) word_d = tx_data_i;
    end

    always_ff @(posedge clk0 or negedge rst_ni) begin
        if (!rst_ni) begin
            hyper_ck_en_o   <= 1'b0;
            hyper_dq_oe_o   <= 1'b0;
            hyper_rwds_oe_o <= 1'b0;
            hyper_cs_no     <= '1;
        end else begin
            hyper_ck_en_o   <= ck_en_i;
            hyper_dq_oe_o   <= (state_i == CA) || wr_data;
            hyper_rwds_oe_o <= wr_data;  // memory owns RWDS otherwise
            hyper_cs_no     <= ~({NUM_CS{cs_en_i}} & cs_i);
        end
    end

    always_ff @(posedge clk0) begin
        hyper_dq_o   <= word_d;
        hyper_rwds_o <= wr_data ? tx_strb_i : '0;
    end

    assert property (@(posedge clk0) disable iff (!rst_ni) $onehot0(~hyper_cs_no));

endmodule

//--- hyper_rx_result.sv
/*
 * One-word read result buffer with valid/ready.
 * A word is loaded when capture_i and RWDS are both high, and shows
 * on rx_valid_o the cycle after. It holds until taken.
 */
`timescale 1ns/100ps

module hyper_rx_result import hyper_pkg::*; (
    input  logic              clk0,
    input  logic              rst_ni,
    input  logic              capture_i,
    input  logic              last_i,
    input  logic [WORD_W-1:0] hyper_dq_i,
    input  logic              hyper_rwds_i,
    input  logic              rx_ready_i,
    output logic              rx_valid_o,
    output logic [WORD_W-1:0] rx_data_o,
    output logic              rx_last_o,
    output logic              full_o,
    output logic              take_o
);

    logic load;

    assign load   = capture_i && hyper_rwds_i;  // RWDS qualifies the word
    assign take_o = rx_valid_o && rx_ready_i;
    assign full_o = rx_valid_o;

    always_ff @(posedge clk0 or negedge rst_ni) begin
        if (!rst_ni) begin
            rx_valid_o <= 1'b0;
        end else if (load) begin
            rx_valid_o <= 1'b1;
        end else if (take_o) begin
            rx_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk0) begin
        if (load) begin
            rx_data_o <= hyper_dq_i;
            rx_last_o <= last_i;
        end
    end

    // sequencer flow control must never overrun a held word
    assert property (@(posedge clk0) disable iff (!rst_ni) load |-> (!full_o || take_o));

endmodule

//--- hyper_phy.sv
/*
 * HyperBus-style PHY core, single clock, one 16-bit bus word per cycle.
 * hyper_ck_en_o marks the cycles in which the memory may advance.
 * Read words must arrive on hyper_dq_i in their enabled cycle with RWDS high.
 * Transaction inputs must hold while trans_valid_i is high.
 */
`timescale 1ns/100ps

module hyper_phy import hyper_pkg::*; (
    input  logic               clk0,
    input  logic               rst_ni,
    input  logic [CFG_W-1:0]   cfg_latency_i,
    input  logic               cfg_add_latency_i,
    input  logic [CFG_W-1:0]   cfg_recovery_i,
    input  logic               trans_valid_i,
    output logic               trans_ready_o,
    input  logic [ADDR_W-1:0]  trans_address_i,
    input  logic [NUM_CS-1:0]  trans_cs_i,
    input  logic               trans_write_i,
    input  logic [BURST_W-1:0] trans_burst_i,
    input  logic               trans_burst_type_i,
    input  logic               trans_address_space_i,
    input  logic               tx_valid_i,
    output logic               tx_ready_o,
    input  logic [WORD_W-1:0]  tx_data_i,
    input  logic [STRB_W-1:0]  tx_strb_i,
    output logic               rx_valid_o,
    input  logic               rx_ready_i,
    output logic [WORD_W-1:0]  rx_data_o,
    output logic               rx_last_o,
    output logic               b_valid_o,
    output logic [NUM_CS-1:0]  hyper_cs_no,
    output logic               hyper_ck_en_o,
    output logic [WORD_W-1:0]  hyper_dq_o,
    output logic               hyper_dq_oe_o,
    output logic [STRB_W-1:0]  hyper_rwds_o,
    output logic               hyper_rwds_oe_o,
    input  logic [WORD_W-1:0]  hyper_dq_i,
    input  logic               hyper_rwds_i
);

    logic               load, write, ck_en, cs_en, rx_full, rx_take, last, capture;
    logic [NUM_CS-1:0]  cs;
    logic [BURST_W-1:0] burst;
    logic [1:0]         ca_sel;
    hyper_ca_u          ca;
    hyper_state_e       state;

    hyper_ca_decode i_ca_decode (
        .clk0, .rst_ni, .load_i(load),
        .trans_address_i, .trans_cs_i, .trans_write_i, .trans_burst_i,
        .trans_burst_type_i, .trans_address_space_i,
        .cs_o(cs), .write_o(write), .burst_o(burst), .ca_o(ca)
    );

    hyper_seq i_seq (
        .clk0, .rst_ni, .trans_valid_i,
        .cfg_latency_i, .cfg_add_latency_i, .cfg_recovery_i,
        .write_i(write), .burst_i(burst), .tx_valid_i,
        .rx_full_i(rx_full), .rx_take_i(rx_take), .rwds_i(hyper_rwds_i),
        .load_o(load), .trans_ready_o, .tx_ready_o, .b_valid_o,
        .state_o(state), .ca_sel_o(ca_sel), .ck_en_o(ck_en), .cs_en_o(cs_en),
        .rx_last_o(last), .capture_o(capture)
    );

    hyper_bus_drive i_bus_drive (
        .clk0, .rst_ni, .state_i(state), .ca_i(ca), .ca_sel_i(ca_sel),
        .ck_en_i(ck_en), .cs_en_i(cs_en), .cs_i(cs), .tx_data_i, .tx_strb_i,
        .hyper_dq_o, .hyper_rwds_o, .hyper_dq_oe_o, .hyper_rwds_oe_o,
        .hyper_ck_en_o, .hyper_cs_no
    );

    hyper_rx_result i_rx_result (
        .clk0, .rst_ni, .capture_i(capture), .last_i(last),
        .hyper_dq_i, .hyper_rwds_i, .rx_ready_i,
        .rx_valid_o, .rx_data_o, .rx_last_o, .full_o(rx_full), .take_o(rx_take)
    );

endmodule

//--- tb_hyper_mem.sv
/*
 * Behavioral memory for the PHY testbench, one bus word per enabled cycle.
 * Holds 256 words; the word address is byte address bits 8..1, linear bursts only.
 * force_rwds_i doubles the latency and shows RWDS high in the command phase.
 * Read words are returned in the same enabled cycle with RWDS high.
 */
`timescale 1ns/100ps

module tb_hyper_mem import hyper_pkg::*; (
    input  logic              clk0,
    input  logic              rst_ni,
    input  logic [CFG_W-1:0]  lat_i,
    input  logic              add_lat_i,
    input  logic              force_rwds_i,
    input  logic [NUM_CS-1:0] cs_ni,
    input  logic              ck_en_i,
    input  logic [WORD_W-1:0] dq_i,
    input  logic [STRB_W-1:0] strb_i,
    input  logic              strb_oe_i,
    output logic [WORD_W-1:0] dq_o,
    output logic              rwds_o,
    output logic [1:0]        phase_o,  // 0 command, 1 latency, 2 data
    output logic [7:0]        cnt_o
);

    logic [WORD_W-1:0] mem [256];
    hyper_ca_u         ca;
    logic              selected;
    logic [7:0]        lat_total;
    logic [7:0]        base;
    logic [7:0]        waddr;

    function automatic logic [15:0] fill_word(input logic [7:0] a);
        return {a ^ 8'h5a, ~a};
    endfunction

    initial begin
        for (int i = 0; i < 256; i++) mem[i] = fill_word(i[7:0]);
    end

    assign selected  = cs_ni != '1;
    assign lat_total = (add_lat_i || force_rwds_i) ? 8'(2 * lat_i) : 8'(lat_i);
    assign phase_o   = (cnt_o < 8'd3) ? 2'd0 : (cnt_o < 8'd3 + lat_total) ? 2'd1 : 2'd2;
    assign base      = {ca.f.addr_hi[5:0], ca.f.addr_lo[2:1]};
    assign waddr     = base + (cnt_o - 8'd3 - lat_total);  // wraps in the array
    assign dq_o      = mem[waddr];
    assign rwds_o    = selected && ck_en_i &&
                       ((phase_o == 2'd0 && force_rwds_i) || (phase_o == 2'd2 && ca.f.read));

    always_ff @(posedge clk0 or negedge rst_ni) begin
        if (!rst_ni) begin
            cnt_o <= '0;
        end else if (!selected) begin
            cnt_o <= '0;
        end else if (ck_en_i) begin
            cnt_o <= cnt_o + 8'd1;
        end
    end

    always @(posedge clk0) begin
        if (selected && ck_en_i && phase_o == 2'd0) ca.w[2 - cnt_o[1:0]] <= dq_i;
        if (selected && ck_en_i && phase_o == 2'd2 && !ca.f.read && strb_oe_i) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (strb_i[b]) mem[waddr][8*b +: 8] <= dq_i[8*b +: 8];  // masked bytes kept
            end
        end
    end

endmodule

//--- tb_hyper_phy.sv
/*
 * Testbench for hyper_phy: write bursts with random strobes and stalls,
 * each read back under random rx_ready_i. Checks are concurrent assertions.
 * Addresses are word aligned and wrap inside the 256-word model.
 */
`timescale 1ns/100ps

module tb_hyper_phy import hyper_pkg::*;;

    localparam int NUM_PAIRS = 6;
    localparam int NUM_TRANS = 2 * NUM_PAIRS;
    localparam int MAX_CYCLES = 200 * NUM_TRANS;

    logic clk0, rst_ni;
    logic [CFG_W-1:0] cfg_latency_i, cfg_recovery_i;
    logic cfg_add_latency_i, trans_valid_i, trans_ready_o, trans_write_i;
    logic [ADDR_W-1:0] trans_address_i;
    logic [NUM_CS-1:0] trans_cs_i, hyper_cs_no;
    logic [BURST_W-1:0] trans_burst_i;
    logic trans_burst_type_i, trans_address_space_i;
    logic tx_valid_i, tx_ready_o, rx_valid_o, rx_ready_i, rx_last_o, b_valid_o;
    logic [WORD_W-1:0] tx_data_i, rx_data_o, hyper_dq_o, hyper_dq_i;
    logic [STRB_W-1:0] tx_strb_i, hyper_rwds_o;
    logic hyper_ck_en_o, hyper_dq_oe_o, hyper_rwds_oe_o, hyper_rwds_i;

    logic [1:0]         mem_phase;
    logic [7:0]         mem_cnt;
    logic               force_rwds;
    logic [WORD_W-1:0]  ref_mem [256];
    logic [2:0][15:0]   exp_ca_w;
    logic               cur_write, started, busy;
    logic [7:0]         cur_base, cur_len, rd_idx, wr_cnt, b_cnt, cs_high;
    logic [CFG_W-1:0]   rec_used;
    logic [WORD_W-1:0]  exp_rd;
    logic               rx_hs;
    logic [31:0]        rnd, seed;
    int                 cycles;

    hyper_phy hyper_phy_i (.*);

    tb_hyper_mem u_mem (
        .clk0, .rst_ni, .lat_i(cfg_latency_i), .add_lat_i(cfg_add_latency_i),
        .force_rwds_i(force_rwds), .cs_ni(hyper_cs_no), .ck_en_i(hyper_ck_en_o),
        .dq_i(hyper_dq_o), .strb_i(hyper_rwds_o), .strb_oe_i(hyper_rwds_oe_o),
        .dq_o(hyper_dq_i), .rwds_o(hyper_rwds_i), .phase_o(mem_phase), .cnt_o(mem_cnt)
    );

    initial begin
        clk0 = 1'b0;
        forever #2 clk0 = ~clk0;
    end

    task automatic fail_run();
        $display("Testbench failed");
        $fatal(1);
    endtask

    assign rx_hs  = rx_valid_o && rx_ready_i;
    assign exp_rd = ref_mem[8'(cur_base + rd_idx)];

    // bookkeeping of the running transaction, seen from the user ports
    always_ff @(posedge clk0 or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_idx   <= '0;
            wr_cnt   <= '0;
            b_cnt    <= '0;
            busy     <= 1'b0;
            rec_used <= '0;
            cs_high  <= '0;
        end else begin
            if (trans_valid_i && trans_ready_o) begin
                rd_idx <= '0;
                wr_cnt <= '0;
                b_cnt  <= '0;
                busy   <= 1'b1;
            end else begin
                if (rx_hs) rd_idx <= rd_idx + 8'd1;
                if (tx_valid_i && tx_ready_o) wr_cnt <= wr_cnt + 8'd1;
                if (b_valid_o) b_cnt <= b_cnt + 8'd1;
                if (b_valid_o || (rx_hs && rx_last_o)) begin
                    busy     <= 1'b0;
                    rec_used <= cfg_recovery_i;
                end
            end
            if (hyper_cs_no != '1) cs_high <= '0;
            else if (cs_high != 8'hff) cs_high <= cs_high + 8'd1;
        end
    end

    always @(posedge clk0) begin
        cycles <= cycles + 1;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            fail_run();
        end
    end

    assert property (@(posedge clk0) disable iff (!rst_ni) !started |->
        !trans_ready_o && !tx_ready_o && !rx_valid_o && !b_valid_o &&
        !hyper_ck_en_o && hyper_cs_no == '1)
    else begin
        $display("outputs not idle after reset");
        fail_run();
    end

    assert property (@(posedge clk0) disable iff (!rst_ni)
        hyper_ck_en_o && mem_phase == 2'd0 |->
        hyper_dq_oe_o && hyper_dq_o == exp_ca_w[2 - mem_cnt[1:0]])
    else begin
        $display("[ERROR] hyper_dq_o got %h expected %h",
                 $sampled(hyper_dq_o), $sampled(exp_ca_w[2 - mem_cnt[1:0]]));
        fail_run();
    end

    // PHY must not drive the bus before the memory's latency has run out
    assert property (@(posedge clk0) disable iff (!rst_ni)
        hyper_ck_en_o && mem_phase == 2'd1 |-> !hyper_dq_oe_o && !hyper_rwds_oe_o)
    else begin
        $display("bus driven during the latency phase");
        fail_run();
    end

    assert property (@(posedge clk0) disable iff (!rst_ni)
        hyper_ck_en_o && mem_phase == 2'd2 |->
        hyper_dq_oe_o == cur_write && hyper_rwds_oe_o == cur_write)
    else begin
        $display("data phase does not start after the expected latency");
        fail_run();
    end

    assert property (@(posedge clk0) disable iff (!rst_ni) rx_hs |-> rx_data_o == exp_rd)
    else begin
        $display("[ERROR] rx_data_o got %h expected %h", $sampled(rx_data_o), $sampled(exp_rd));
        fail_run();
    end

    assert property (@(posedge clk0) disable iff (!rst_ni)
        rx_hs |-> rx_last_o == (rd_idx == cur_len - 8'd1))
    else begin
        $display("[ERROR] rx_last_o got %h expected %h", $sampled(rx_last_o),
                 $sampled(rd_idx) == $sampled(cur_len) - 8'd1);
        fail_run();
    end

    assert property (@(posedge clk0) disable iff (!rst_ni)
        rx_valid_o |-> !cur_write && rd_idx < cur_len)
    else begin
        $display("read word beyond the burst length");
        fail_run();
    end

    assert property (@(posedge clk0) disable iff (!rst_ni) rx_valid_o && !rx_ready_i |=>
        rx_valid_o && $stable(rx_data_o) && $stable(rx_last_o))
    else begin
        $display("read word changed while held");
        fail_run();
    end

    assert property (@(posedge clk0) disable iff (!rst_ni) b_valid_o |->
        cur_write && wr_cnt == cur_len && b_cnt == 8'd0 && $past(tx_valid_i && tx_ready_o))
    else begin
        $display("write response not single or not after the last word");
        fail_run();
    end

    assert property (@(posedge clk0) disable iff (!rst_ni)
        trans_ready_o |-> !busy && cs_high >= 8'(rec_used))
    else begin
        $display("transaction accepted before recovery ended");
        fail_run();
    end

    task automatic start_trans(input logic wr, input logic [31:0] addr, input logic [7:0] len);
        @(posedge clk0);
        rnd       = $random(seed);
        exp_ca_w  = {~wr, rnd[1], rnd[0], addr[31:3], 13'd0, addr[2:0]};
        cur_write = wr;
        cur_base  = addr[8:1];
        cur_len   = len;
        started   = 1'b1;
        trans_valid_i         <= 1'b1;
        trans_write_i         <= wr;
        trans_address_i       <= addr;
        trans_burst_i         <= BURST_W'(len);
        trans_address_space_i <= rnd[1];
        trans_burst_type_i    <= rnd[0];
        trans_cs_i            <= rnd[2] ? 2'b10 : 2'b01;
        do @(negedge clk0); while (!trans_ready_o);
        @(posedge clk0);
        trans_valid_i <= 1'b0;
    endtask

    task automatic write_burst(input logic [31:0] addr, input logic [7:0] len);
        logic [7:0] i;
        logic [7:0] a;
        start_trans(1'b1, addr, len);
        i = '0;
        while (i < len) begin
            rnd = $random(seed);
            tx_valid_i <= rnd[1:0] != 2'b00;  // stalls now and then
            tx_data_i  <= rnd[31:16];
            tx_strb_i  <= rnd[3:2];
            @(negedge clk0);
            if (tx_valid_i && tx_ready_o) begin
                a = cur_base + i;
                if (tx_strb_i[0]) ref_mem[a][7:0] = tx_data_i[7:0];
                if (tx_strb_i[1]) ref_mem[a][15:8] = tx_data_i[15:8];
                i = i + 8'd1;
            end
            @(posedge clk0);
        end
        tx_valid_i <= 1'b0;
        do @(negedge clk0); while (!b_valid_o);
    endtask

    task automatic read_burst(input logic [31:0] addr, input logic [7:0] len);
        start_trans(1'b0, addr, len);
        while (rd_idx != cur_len || busy) begin
            rnd = $random(seed);
            rx_ready_i <= rnd[0];
            @(negedge clk0);
            @(posedge clk0);
        end
        rx_ready_i <= 1'b0;
    endtask

    initial begin
        logic [31:0] addr;
        logic [7:0]  len;
        seed = 24274;
        cycles = 0;
        started = 1'b0;
        cur_write = 1'b0;
        cur_base = '0;
        cur_len = 8'd1;
        exp_ca_w = '0;
        force_rwds = 1'b0;
        for (int i = 0; i < 256; i++) ref_mem[i] = {8'(i) ^ 8'h5a, ~8'(i)};
        rst_ni = 1'b0;
        cfg_latency_i = 4'd1;
        cfg_add_latency_i = 1'b0;
        cfg_recovery_i = 4'd1;
        trans_valid_i = 1'b0;
        trans_address_i = '0;
        trans_cs_i = 2'b01;
        trans_write_i = 1'b0;
        trans_burst_i = '0;
        trans_burst_type_i = 1'b0;
        trans_address_space_i = 1'b0;
        tx_valid_i = 1'b0;
        tx_data_i = '0;
        tx_strb_i = '0;
        rx_ready_i = 1'b0;
        repeat (4) @(posedge clk0);
        rst_ni <= 1'b1;
        repeat (3) @(posedge clk0);
        for (int k = 0; k < NUM_PAIRS; k++) begin
            rnd  = $random(seed);
            addr = {rnd[31:1], 1'b0};
            rnd  = $random(seed);
            len  = 8'(rnd[2:0]) + 8'd1;
            cfg_latency_i     <= 4'(k % 4 + 1);
            cfg_recovery_i    <= 4'(k % 4);
            cfg_add_latency_i <= k == 2;  // doubled by config alone, RWDS low
            force_rwds        <= k[0];
            write_burst(addr, len);
            read_burst(addr, len);
        end
        repeat (10) @(posedge clk0);
        if (busy) begin
            $display("last transaction did not finish");
            fail_run();
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

//--- src.f
hyper_pkg.sv
hyper_ca_decode.sv
hyper_seq.sv
hyper_bus_drive.sv
hyper_rx_result.sv
hyper_phy.sv
tb_hyper_mem.sv
tb_hyper_phy.sv
